/* verilog/tsc_pkg.sv */
`default_nettype none

package tsc_pkg;

    localparam int word_size = 16;
    localparam int num_regs  = 4;

    localparam logic [3:0] alu_opcode = 4'd15;
    localparam logic [3:0] adi_opcode = 4'd4;
    localparam logic [3:0] ori_opcode = 4'd5;
    localparam logic [3:0] lhi_opcode = 4'd6;
    localparam logic [3:0] lwd_opcode = 4'd7;
    localparam logic [3:0] swd_opcode = 4'd8;
    localparam logic [3:0] bne_opcode = 4'd0;
    localparam logic [3:0] beq_opcode = 4'd1;
    localparam logic [3:0] bgz_opcode = 4'd2;
    localparam logic [3:0] blz_opcode = 4'd3;
    localparam logic [3:0] jmp_opcode = 4'd9;
    localparam logic [3:0] jal_opcode = 4'd10;
    localparam logic [3:0] jpr_opcode = 4'd15; // Shares R-type opcode
    localparam logic [3:0] jrl_opcode = 4'd15;

    localparam logic [5:0] func_add = 6'd0;
    localparam logic [5:0] func_sub = 6'd1;
    localparam logic [5:0] func_and = 6'd2;
    localparam logic [5:0] func_orr = 6'd3;
    localparam logic [5:0] func_not = 6'd4;
    localparam logic [5:0] func_tcp = 6'd5;
    localparam logic [5:0] func_shl = 6'd6;
    localparam logic [5:0] func_shr = 6'd7;
    localparam logic [5:0] func_jpr = 6'd25;
    localparam logic [5:0] func_jrl = 6'd26;

    localparam logic [2:0] alu_add = 3'b000;
    localparam logic [2:0] alu_sub = 3'b001;
    localparam logic [2:0] alu_and = 3'b010;
    localparam logic [2:0] alu_or  = 3'b011;
    localparam logic [2:0] alu_not = 3'b100;
    localparam logic [2:0] alu_tcp = 3'b101;
    localparam logic [2:0] alu_shl = 3'b110;
    localparam logic [2:0] alu_shr = 3'b111;

    localparam logic [1:0] link_reg = 2'd2;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm8;
    } i_fmt_t;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target12;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic [word_size-1:0] pc;
        instr_u               instr;
        logic                 valid;
    } fetch_packet_t;

    typedef struct packed {
        logic       alu_src;
        logic [2:0] alu_op;
        logic       reg_write;
        logic       write_rd;   // R-type writes rd, else rt
        logic       mem_read;
        logic       mem_to_reg;
        logic       mem_write;
        logic       pc_to_reg;
        logic       jump;
        logic       jump_reg;
        logic       branch;
    } ctrl_t;

    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [word_size-1:0] addr;
        logic [word_size-1:0] wdata;
    } data_req_t;

endpackage

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 redirect,
    input  logic [word_size-1:0] redirect_pc,
    output logic [word_size-1:0] instr_addr,
    output logic [word_size-1:0] fetch_pc
);

    logic [word_size-1:0] pc;
    logic [word_size-1:0] pc_next;

    assign pc_next = redirect ? redirect_pc : pc + 1'b1; // Taken transfer wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign instr_addr = pc;
    assign fetch_pc   = pc;   // Tag travels with the word

    // An unknown redirect target from execute would show up here
    pc_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(pc));

endmodule

`default_nettype wire

/* verilog/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic [word_size-1:0] fetch_pc,
    input  instr_u               instr_data,
    output fetch_packet_t        packet
);

    always_ff @(posedge clk) begin
        if (reset) begin
            packet.valid <= 1'b0;
        end else begin
            packet.valid <= !flush;   // Squash wrong-path word
        end
    end

    always_ff @(posedge clk) begin
        packet.pc    <= fetch_pc;
        packet.instr <= instr_data;
    end

    valid_after_reset: assert property (@(posedge clk) reset |=> !packet.valid);

    valid_after_flush: assert property (
        @(posedge clk) disable iff (reset) flush |=> !packet.valid
    );

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit import tsc_pkg::*; (
    input  instr_u instr,
    output ctrl_t  ctrl
);

    always_comb begin
        ctrl = '0;
        case (instr.r.opcode)
            alu_opcode: begin
                case (instr.r.func)
                    func_add: ctrl.alu_op = alu_add;
                    func_sub: ctrl.alu_op = alu_sub;
                    func_and: ctrl.alu_op = alu_and;
                    func_orr: ctrl.alu_op = alu_or;
                    func_not: ctrl.alu_op = alu_not;
                    func_tcp: ctrl.alu_op = alu_tcp;
                    func_shl: ctrl.alu_op = alu_shl;
                    func_shr: ctrl.alu_op = alu_shr;
                    default:  ctrl.alu_op = alu_add;
                endcase
                // Arithmetic codes occupy 0 to 7
                if (instr.r.func <= func_shr) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.write_rd  = 1'b1;
                end
                if (instr.r.func == func_jpr || instr.r.func == func_jrl) begin
                    ctrl.jump     = 1'b1;
                    ctrl.jump_reg = 1'b1;
                end
                if (instr.r.func == func_jrl) begin
                    ctrl.pc_to_reg = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            adi_opcode: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
                ctrl.reg_write = 1'b1;
            end
            ori_opcode: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_or;
                ctrl.reg_write = 1'b1;
            end
            lhi_opcode: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_or;   // Zero or shifted imm
                ctrl.reg_write = 1'b1;
            end
            lwd_opcode: begin
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = alu_add;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            swd_opcode: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
                ctrl.mem_write = 1'b1;
            end
            bne_opcode, beq_opcode, bgz_opcode, blz_opcode: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;   // Zero result means equal
            end
            jmp_opcode: begin
                ctrl.jump = 1'b1;
            end
            jal_opcode: begin
                ctrl.jump      = 1'b1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = '0;
        endcase
        mem_excl: assert (!(ctrl.mem_read && ctrl.mem_write));
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import tsc_pkg::*; (
    input  logic [2:0]           op,
    input  logic [word_size-1:0] a,
    input  logic [word_size-1:0] b,
    output logic [word_size-1:0] result
);

    always_comb begin
        result = '0;
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_not: result = ~a;
            alu_tcp: result = ~a + 1'b1;
            alu_shl: result = a << 1;
            alu_shr: result = $signed(a) >>> 1;   // Keeps sign bit
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [1:0]           rs_addr,
    input  logic [1:0]           rt_addr,
    input  logic [1:0]           write_addr,
    input  logic                 write_en,
    input  logic [word_size-1:0] write_data,
    output logic [word_size-1:0] rs_data,
    output logic [word_size-1:0] rt_data
);

    logic [word_size-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    assign rs_data = regs[rs_addr];   // No bypass needed
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

/* verilog/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_packet_t        packet,
    input  logic [word_size-1:0] data_rdata,
    output data_req_t            data_req,
    output logic                 redirect,
    output logic [word_size-1:0] redirect_pc
);

    ctrl_t                ctrl;
    logic [word_size-1:0] rs_data;
    logic [word_size-1:0] rt_data;
    logic [word_size-1:0] imm_sext;
    logic [word_size-1:0] imm_ext;
    logic [word_size-1:0] alu_a;
    logic [word_size-1:0] alu_b;
    logic [word_size-1:0] alu_result;
    logic [word_size-1:0] pc_plus1;
    logic [word_size-1:0] write_data;
    logic [1:0]           write_addr;
    logic                 is_lhi;
    logic                 taken;

    control_unit control_unit_inst (
        .instr (packet.instr),
        .ctrl  (ctrl)
    );

    assign is_lhi   = packet.instr.i.opcode == lhi_opcode;
    assign imm_sext = {{8{packet.instr.i.imm8[7]}}, packet.instr.i.imm8};

    always_comb begin
        if (packet.instr.i.opcode == ori_opcode) begin
            imm_ext = {8'h00, packet.instr.i.imm8};
        end else if (is_lhi) begin
            imm_ext = {packet.instr.i.imm8, 8'h00};
        end else begin
            imm_ext = imm_sext;
        end
    end

    assign alu_a = is_lhi ? '0 : rs_data;
    assign alu_b = ctrl.alu_src ? imm_ext : rt_data;

    alu alu_inst (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    assign pc_plus1 = packet.pc + 1'b1;

    always_comb begin
        case (packet.instr.i.opcode)
            bne_opcode: taken = alu_result != '0;
            beq_opcode: taken = alu_result == '0;
            bgz_opcode: taken = !rs_data[word_size-1] && rs_data != '0;
            blz_opcode: taken = rs_data[word_size-1];
            default:    taken = 1'b0;
        endcase
    end

    assign redirect = packet.valid && (ctrl.jump || (ctrl.branch && taken));

    always_comb begin
        if (ctrl.jump_reg) begin
            redirect_pc = rs_data;
        end else if (ctrl.jump) begin
            redirect_pc = {packet.pc[15:12], packet.instr.j.target12};
        end else begin
            redirect_pc = pc_plus1 + imm_sext;   // Branch target
        end
    end

    assign data_req.read  = packet.valid && ctrl.mem_read;
    assign data_req.write = packet.valid && ctrl.mem_write;
    assign data_req.addr  = alu_result;
    assign data_req.wdata = rt_data;

    always_comb begin
        if (ctrl.pc_to_reg) begin
            write_addr = link_reg;
        end else if (ctrl.write_rd) begin
            write_addr = packet.instr.r.rd;
        end else begin
            write_addr = packet.instr.r.rt;
        end
    end

    assign write_data = ctrl.pc_to_reg  ? pc_plus1 :
                        ctrl.mem_to_reg ? data_rdata : alu_result;

    register_file register_file_inst (
        .clk        (clk),
        .reset      (reset),
        .rs_addr    (packet.instr.r.rs),
        .rt_addr    (packet.instr.r.rt),
        .write_addr (write_addr),
        .write_en   (packet.valid && ctrl.reg_write),
        .write_data (write_data),
        .rs_data    (rs_data),
        .rt_data    (rt_data)
    );

    // Squashed slots from the buffer must leave no trace
    no_side_effect: assert property (
        @(posedge clk) disable iff (reset) !packet.valid |-> !data_req.write && !redirect
    );

endmodule

`default_nettype wire

/* verilog/tsc_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tsc_core import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic [word_size-1:0] instr_addr,
    input  instr_u               instr_data,
    output data_req_t            data_req,
    input  logic [word_size-1:0] data_rdata
);

    logic                 redirect;
    logic [word_size-1:0] redirect_pc;
    logic [word_size-1:0] fetch_pc;
    fetch_packet_t        packet;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_addr  (instr_addr),
        .fetch_pc    (fetch_pc)
    );

    fetch_buffer fetch_buffer_inst (
        .clk        (clk),
        .reset      (reset),
        .flush      (redirect),   // Redirect kills the younger word
        .fetch_pc   (fetch_pc),
        .instr_data (instr_data),
        .packet     (packet)
    );

    execute_unit execute_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .packet      (packet),
        .data_rdata  (data_rdata),
        .data_req    (data_req),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

/* dv/tsc_ref_model.svh */
`ifndef TSC_REF_MODEL_SVH
`define TSC_REF_MODEL_SVH

bit protect [prog_len];   // ORI and register jump slots of a setup sequence

// Forward target that never lands between an ORI and its register jump
function automatic int pick_target(input int pos, input logic [3:0] span);
    int tgt;
    tgt = pos + 1 + int'(span);
    if (tgt > prog_len - 1) begin
        tgt = prog_len - 1;
    end
    while (protect[tgt]) begin
        tgt++;
    end
    return tgt;
endfunction

// Built from the end backward so every later slot is already known
task automatic gen_program();
    logic [31:0] r;
    logic [31:0] f;
    instr_u      ins;
    int          pos;
    int          tgt;
    foreach (protect[i]) protect[i] = 1'b0;
    imem[prog_len-1] = {jmp_opcode, 12'(prog_len - 1)};   // Final self-jump
    pos = prog_len - 2;
    while (pos >= 0) begin
        r = lcg_next();
        f = lcg_next();
        ins = f[31:16];
        tgt = pick_target(pos, r[11:8]);
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                ins.r.opcode = alu_opcode;
                ins.r.func   = {3'b000, r[6:4]};
            end
            4'd4, 4'd15: ins.i.opcode = adi_opcode;
            4'd5: ins.i.opcode = ori_opcode;
            4'd6: ins.i.opcode = lhi_opcode;
            4'd7: ins.i.opcode = lwd_opcode;
            4'd8, 4'd9, 4'd14: ins.i.opcode = swd_opcode;
            4'd10: begin
                ins.i.opcode = {2'b00, r[5:4]};   // BNE BEQ BGZ BLZ
                ins.i.imm8   = 8'(tgt - pos - 1);
            end
            4'd11, 4'd12: begin
                ins.j.opcode   = (r[3:0] == 4'd12) ? jal_opcode : jmp_opcode;
                ins.j.target12 = 12'(tgt);
            end
            default: begin
                if (pos >= 2) begin
                    imem[pos]   = {alu_opcode, f[1:0], f[5:4], 2'd0,
                                   f[8] ? func_jrl : func_jpr};
                    imem[pos-1] = {ori_opcode, f[1:0], f[1:0], 8'(tgt)};
                    protect[pos]   = 1'b1;
                    protect[pos-1] = 1'b1;
                    pos -= 2;
                    ins = {lhi_opcode, f[3:2], f[1:0], 8'h00};   // Clears upper byte
                end else begin
                    ins.i.opcode = adi_opcode;
                end
            end
        endcase
        imem[pos] = ins;
        pos--;
    end
endtask

// ISA level execution on the model's own data memory
task automatic run_model();
    logic [15:0] pc;
    logic [15:0] nxt;
    logic [15:0] rs_v;
    logic [15:0] rt_v;
    logic [15:0] imm_s;
    instr_u      ins;
    int          steps;
    pc = '0;
    steps = 0;
    foreach (mdl_regs[i]) mdl_regs[i] = '0;
    while (pc != last_pc && steps < 2 * prog_len) begin
        ins   = imem[pc[7:0]];
        rs_v  = mdl_regs[ins.i.rs];
        rt_v  = mdl_regs[ins.i.rt];
        imm_s = {{8{ins.i.imm8[7]}}, ins.i.imm8};
        nxt   = pc + 16'd1;
        case (ins.i.opcode)
            alu_opcode: begin
                case (ins.r.func)
                    func_add: mdl_regs[ins.r.rd] = rs_v + rt_v;
                    func_sub: mdl_regs[ins.r.rd] = rs_v - rt_v;
                    func_and: mdl_regs[ins.r.rd] = rs_v & rt_v;
                    func_orr: mdl_regs[ins.r.rd] = rs_v | rt_v;
                    func_not: mdl_regs[ins.r.rd] = ~rs_v;
                    func_tcp: mdl_regs[ins.r.rd] = 16'd0 - rs_v;
                    func_shl: mdl_regs[ins.r.rd] = {rs_v[14:0], 1'b0};
                    func_shr: mdl_regs[ins.r.rd] = {rs_v[15], rs_v[15:1]};
                    func_jpr: nxt = rs_v;
                    func_jrl: begin
                        mdl_regs[link_reg] = pc + 16'd1;
                        nxt = rs_v;
                    end
                    default: ;
                endcase
            end
            adi_opcode: mdl_regs[ins.i.rt] = rs_v + imm_s;
            ori_opcode: mdl_regs[ins.i.rt] = rs_v | {8'h00, ins.i.imm8};
            lhi_opcode: mdl_regs[ins.i.rt] = {ins.i.imm8, 8'h00};
            lwd_opcode: begin
                mdl_regs[ins.i.rt] = mdl_dmem[8'(rs_v + imm_s)];
                exp_load_addr.push_back(rs_v + imm_s);
            end
            swd_opcode: begin
                mdl_dmem[8'(rs_v + imm_s)] = rt_v;
                exp_addr.push_back(rs_v + imm_s);
                exp_data.push_back(rt_v);
            end
            bne_opcode: if (rs_v != rt_v) nxt = pc + 16'd1 + imm_s;
            beq_opcode: if (rs_v == rt_v) nxt = pc + 16'd1 + imm_s;
            bgz_opcode: if ($signed(rs_v) > 0) nxt = pc + 16'd1 + imm_s;
            blz_opcode: if ($signed(rs_v) < 0) nxt = pc + 16'd1 + imm_s;
            jmp_opcode: nxt = {pc[15:12], ins.j.target12};
            jal_opcode: begin
                mdl_regs[link_reg] = pc + 16'd1;
                nxt = {pc[15:12], ins.j.target12};
            end
            default: ;
        endcase
        pc = nxt;
        steps++;
    end
    if (pc != last_pc) begin
        errors++;
        $display("Reference model never reached the final jump");
    end
endtask

`endif

/* dv/tsc_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tsc_core_tb import tsc_pkg::*; ();

    localparam int          prog_len    = 256;
    localparam int          mem_len     = 256;
    localparam logic [15:0] last_pc     = 16'(prog_len - 1);
    localparam int          cycle_limit = 2 * prog_len + 64;   // Every word once plus bubbles

    logic        clk;
    logic        reset;
    logic [15:0] instr_addr;
    instr_u      instr_data;
    data_req_t   data_req;
    logic [15:0] data_rdata;

    instr_u      imem [prog_len];
    logic [15:0] dmem [mem_len];
    logic [15:0] mdl_dmem [mem_len];
    logic [15:0] mdl_regs [num_regs];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [15:0] exp_load_addr [$];
    logic [31:0] lcg_state;
    int          errors;
    int          store_count;
    int          exp_total;
    int          cycles;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    `include "tsc_ref_model.svh"

    tsc_core tsc_core_inst (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_req   (data_req),
        .data_rdata (data_rdata)
    );

    assign instr_data = imem[instr_addr[7:0]];   // Both memories read combinationally
    assign data_rdata = dmem[data_req.addr[7:0]];

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (data_req.write) begin
            dmem[data_req.addr[7:0]] <= data_req.wdata;
        end
    end

    // Mid-cycle sampling of the store port
    always @(negedge clk) begin
        if (reset || cycles == 0) begin
            check_value("instr_addr", 16'd0, instr_addr);
            check_value("data_req.write", 16'd0, {15'd0, data_req.write});
            check_value("data_req.read", 16'd0, {15'd0, data_req.read});
        end else begin
            if (data_req.write) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("Unexpected store of %h to address %h at %0t",
                             data_req.wdata, data_req.addr, $time);
                end else begin
                    check_value("data_req.addr", exp_addr.pop_front(), data_req.addr);
                    check_value("data_req.wdata", exp_data.pop_front(), data_req.wdata);
                end
                store_count++;
            end
            if (data_req.read) begin
                if (exp_load_addr.size() == 0) begin
                    errors++;
                    $display("Unexpected load from address %h at %0t",
                             data_req.addr, $time);
                end else begin
                    check_value("data_req.addr", exp_load_addr.pop_front(), data_req.addr);
                end
            end
        end
    end

    initial begin
        logic [31:0] fill;
        reset = 1'b1;
        errors = 0;
        store_count = 0;
        cycles = 0;
        lcg_state = 32'h3562bc3e;
        gen_program();
        for (int i = 0; i < mem_len; i++) begin
            fill = lcg_next();
            dmem[i] = fill[31:16];
            mdl_dmem[i] = fill[31:16];
        end
        run_model();
        exp_total = exp_addr.size();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (!(store_count == exp_total && instr_addr == last_pc) && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= cycle_limit) begin
            errors++;
            if (store_count < exp_total) begin
                $display("Timeout: the run ended before all expected stores occurred (%0d of %0d)",
                         store_count, exp_total);
            end else begin
                $display("Timeout: the core never reached the final self-jump");
            end
        end else begin
            repeat (4) @(posedge clk);   // Room for any stray store
        end
        @(negedge clk);
        check_value("store count", 16'(exp_total), 16'(store_count));
        check_value("pending loads", 16'd0, 16'(exp_load_addr.size()));
        for (int i = 0; i < mem_len; i++) begin
            check_value($sformatf("dmem[%0d]", i), mdl_dmem[i], dmem[i]);
        end
        $display("Checked %0d stores in %0d cycles with %0d errors", store_count, cycles, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tsc_core.f */
+incdir+dv
verilog/tsc_pkg.sv
verilog/fetch_unit.sv
verilog/fetch_buffer.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/tsc_core.sv
dv/tsc_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tsc_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tsc_core_tb \
    -f tsc_core.f -o tsc_core_sim

out=$(./obj_dir/tsc_core_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
